//--- Bender.yml
package:
  name: dbg_go

sources:
  - include_dirs:
      - src
    files:
      - src/dbg_cpu_pkg.sv
      - src/dbg_link_pkg.sv
      - src/run_control.sv
      - src/dump_sequencer.sv
      - src/go_phase_ctrl.sv
      - src/dbg_go.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_dbg_go.sv

//--- dbg_go.f
+incdir+src
src/dbg_cpu_pkg.sv
src/dbg_link_pkg.sv
src/run_control.sv
src/dump_sequencer.sv
src/go_phase_ctrl.sv
src/dbg_go.sv
sim/tb_dbg_go.sv

//--- sim/dbg_go_testdata.txt
# bp1 bp2 run_cycles stop_pc halt_mode npc pc ir ctl a b imm y mdr
# run_cycles, halt_mode decimal (0 bp, 1 halt char, 2 other char then halt), others hex
100 200 4 100 0 104 100 8c220004 13 1000 4 4 1004 deadbeef
100 200 9 200 0 204 200 430820 21 7 9 0 10 0
400010 400020 0 400020 0 400024 400020 2021ffff 5 ffffffff 1 ffffffff fffffffe 12345678
1000 2000 17 3000 1 3004 3000 ac620008 31 2000 abcd 8 2008 abcd
1000 2000 3 40 2 44 40 10220003 41 0 0 3 0 cafef00d
fff0 fff4 40 fff4 0 fff8 fff4 8000000 81 80000000 7fffffff 0 ffffffff a5a5a5a5
0 8 25 10 1 14 10 3c01abcd c1 0 0 abcd0000 abcd0000 5a5a5a5a
20 30 1 20 0 24 20 0 1 11111111 22222222 33333333 44444444 55555555
20 30 12 50 2 54 50 fc000000 101 1234567 89abcdef 76543210 fedcba98 f0f0f0f
80000000 80000004 6 80000004 0 80000008 80000004 8fbf0010 13 7ffffff0 10 10 80000000 c0ffee

//--- sim/tb_dbg_go.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbg_defines.svh"

module tb_dbg_go
    import dbg_cpu_pkg::*, dbg_link_pkg::*;
();

    localparam int MAX_TESTS = 32;
    localparam int ITEMS = 39;  // 28 label chars, 9 words, CR LF
    localparam word_t PC_IDLE = 32'hFFFF_FFFC;

    typedef struct packed {
        logic  is_word;
        word_t data;
    } item_t;

    logic       clk;
    logic       rstn;
    mode_t      mode;
    word_t      pc_chk;
    bp_pair_t   bps;
    cpu_state_t cpu;
    rx_rsp_t    rx_rsp;
    logic       rx_req;
    logic       tx_ack;
    tx_req_t    tx;
    logic       cpu_clk;
    logic       finish;

    integer seed = 76027;
    int     n_tests;
    int     n_done;
    int     max_delay;
    int     cycles;
    int     cycle_limit;
    word_t  bp1_a [MAX_TESTS];
    word_t  bp2_a [MAX_TESTS];
    word_t  stop_a [MAX_TESTS];
    int     delay_a [MAX_TESTS];
    int     halt_a [MAX_TESTS];
    word_t  vals [MAX_TESTS][`DBG_NUM_FIELDS];
    item_t  exp_q [$];
    string  labels [`DBG_NUM_FIELDS] =
        '{"NPC", "PC", "IR", "CTL", "A", "B", "IMM", "Y", "MDR"};

    dbg_go dbg_go_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, the DUT did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped");
        end
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_char(input string name, input char_t got, input char_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_quiet();
        check_flag("rx_req", rx_req, 1'b0);
        check_flag("tx.req", tx.req, 1'b0);
        check_flag("cpu_clk", cpu_clk, 1'b0);
        check_flag("finish", finish, 1'b0);
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        word_t v [`DBG_NUM_FIELDS];
        fd = $fopen("sim/dbg_go_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test vector file");
            abort_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#" && n_tests < MAX_TESTS) begin
                n = $sscanf(line, "%h %h %d %h %d %h %h %h %h %h %h %h %h %h",
                            bp1_a[n_tests], bp2_a[n_tests], delay_a[n_tests],
                            stop_a[n_tests], halt_a[n_tests],
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (n != 14) begin
                    $display("malformed test vector line: %s", line);
                    abort_run();
                end
                vals[n_tests] = v;
                if (delay_a[n_tests] > max_delay)
                    max_delay = delay_a[n_tests];
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    // expected stream, label chars then "=" then the word, per field
    task automatic build_expected(input int t);
        int f;
        int i;
        exp_q.delete();
        for (f = 0; f < `DBG_NUM_FIELDS; f++) begin
            for (i = 0; i < labels[f].len(); i++)
                exp_q.push_back(item_t'{1'b0, word_t'(char_t'(labels[f].getc(i)))});
            exp_q.push_back(item_t'{1'b0, word_t'("=")});
            exp_q.push_back(item_t'{1'b1, vals[t][f]});
        end
        exp_q.push_back(item_t'{1'b0, word_t'(`DBG_CR)});
        exp_q.push_back(item_t'{1'b0, word_t'(`DBG_LF)});
        if (exp_q.size() != ITEMS) begin
            $display("reference stream has %0d items", exp_q.size());
            abort_run();
        end
    endtask

    task automatic send_rx_char(input char_t ch);
        int w;
        w = 0;
        do begin
            @(posedge clk);
            w++;
        end while (!rx_req && w < 8);
        if (!rx_req) begin
            $display("receive request did not come back, the run stopped early");
            abort_run();
        end
        rx_rsp <= '{ack: 1'b1, data: ch};
        @(posedge clk);
        rx_rsp <= '{ack: 1'b0, data: '0};
    endtask

    task automatic collect_dump();
        item_t exp;
        word_t held;
        int    d;
        foreach (exp_q[n]) begin
            exp = exp_q[n];
            do @(posedge clk); while (!tx.req);
            check_flag("cpu_clk", cpu_clk, 1'b0);
            check_flag("finish", finish, 1'b0);
            check_flag("tx.is_word", tx.is_word, exp.is_word);
            if (exp.is_word)
                check_word("tx.data", tx.data, exp.data);
            else
                check_char("tx.data", tx.data[7:0], exp.data[7:0]);
            held = tx.data;
            d = $unsigned($random(seed)) % 6;  // host stall
            repeat (d) begin
                @(posedge clk);
                check_flag("tx.req", tx.req, 1'b1);
                check_word("tx.data", tx.data, held);
            end
            tx_ack <= 1'b1;
            @(posedge clk);
            tx_ack <= 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        logic  prev;
        char_t other;
        cpu  <= cpu_state_t'{vals[t][0], vals[t][1], vals[t][2], vals[t][3], vals[t][4],
                             vals[t][5], vals[t][6], vals[t][7], vals[t][8]};
        bps  <= '{bp1: bp1_a[t], bp2: bp2_a[t]};
        mode <= `DBG_GO_CMD;
        build_expected(t);
        do @(posedge clk); while (!cpu_clk);
        prev = 1'b1;
        repeat (delay_a[t]) begin
            @(posedge clk);
            check_flag("cpu_clk", cpu_clk, !prev);
            prev = cpu_clk;
        end
        pc_chk <= stop_a[t];  // matches a bp only in mode 0
        if (halt_a[t] == 2) begin
            other = 8'($random(seed));
            if (other == `DBG_HALT_CHAR)
                other = 8'h58;
            send_rx_char(other);
        end
        if (halt_a[t] != 0)
            send_rx_char(`DBG_HALT_CHAR);
        collect_dump();
        repeat (4) begin
            @(posedge clk);
            check_flag("finish", finish, 1'b1);
            check_flag("cpu_clk", cpu_clk, 1'b0);
        end
        mode   <= '0;
        pc_chk <= PC_IDLE;
        repeat (2) @(posedge clk);
        check_quiet();
        n_done++;
    endtask

    initial begin
        int t;
        mode   = '0;
        pc_chk = PC_IDLE;
        bps    = '0;
        cpu    = '0;
        rx_rsp = '0;
        tx_ack = 1'b0;
        rstn   = 1'b0;
        load_tests();
        cycle_limit = n_tests * (max_delay + ITEMS * 12 + 20) + 100;
        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            check_quiet();
        end
        rstn <= 1'b1;
        repeat (8) begin
            @(posedge clk);
            check_quiet();
            mode <= `DBG_HALT_CHAR;  // anything but go
        end
        mode <= '0;
        for (t = 0; t < n_tests; t++)
            run_test(t);
        if (n_done > 0 && n_done == n_tests) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("no test vectors were run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- src/dbg_cpu_pkg.sv
`default_nettype none
`include "dbg_defines.svh"

package dbg_cpu_pkg;

    typedef logic [`DBG_WORD_W-1:0] word_t;

    // observed cpu registers, in dump order
    typedef struct packed {
        word_t npc;
        word_t pc;
        word_t ir;
        word_t ctl;
        word_t a;
        word_t b;
        word_t imm;
        word_t y;
        word_t mdr;
    } cpu_state_t;

    typedef struct packed {
        word_t bp1;
        word_t bp2;
    } bp_pair_t;

endpackage

`default_nettype wire

//--- src/dbg_defines.svh
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// mode value of the go command, ascii "G"
`define DBG_GO_CMD 8'h47

// host character that stops a run, ascii "H"
`define DBG_HALT_CHAR 8'h48

// datapath widths
`define DBG_WORD_W 32
`define DBG_CHAR_W 8

// npc pc ir ctl a b imm y mdr
`define DBG_NUM_FIELDS 9

// line end of the dump
`define DBG_CR 8'h0D
`define DBG_LF 8'h0A

`endif

//--- src/dbg_go.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_go
    import dbg_cpu_pkg::*, dbg_link_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire mode_t      mode,
    input  wire word_t      pc_chk,
    input  wire bp_pair_t   bps,
    input  wire cpu_state_t cpu,
    input  wire rx_rsp_t    rx_rsp,
    output logic            rx_req,
    input  wire logic       tx_ack,
    output tx_req_t         tx,
    output logic            cpu_clk,
    output logic            finish
);

    logic run_en;
    logic stop;
    logic dump_start;
    logic dump_done;
    logic abort;

    run_control run_control_i (
        .clk     (clk),
        .rstn    (rstn),
        .run_en  (run_en),
        .pc_chk  (pc_chk),
        .bps     (bps),
        .rx_rsp  (rx_rsp),
        .rx_req  (rx_req),
        .cpu_clk (cpu_clk),
        .stop    (stop)
    );

    dump_sequencer dump_sequencer_i (
        .clk        (clk),
        .rstn       (rstn),
        .dump_start (dump_start),
        .abort      (abort),
        .cpu        (cpu),
        .tx_ack     (tx_ack),
        .tx         (tx),
        .dump_done  (dump_done)
    );

    go_phase_ctrl go_phase_ctrl_i (
        .clk        (clk),
        .rstn       (rstn),
        .mode       (mode),
        .stop       (stop),
        .dump_done  (dump_done),
        .run_en     (run_en),
        .dump_start (dump_start),
        .abort      (abort),
        .finish     (finish)
    );

endmodule

`default_nettype wire

//--- src/dbg_link_pkg.sv
`default_nettype none
`include "dbg_defines.svh"

package dbg_link_pkg;
    import dbg_cpu_pkg::*;

    typedef logic [`DBG_CHAR_W-1:0] char_t;
    typedef logic [`DBG_CHAR_W-1:0] mode_t;

    // transmit request, character sits in the low byte when is_word is 0
    typedef struct packed {
        logic  req;
        logic  is_word;
        word_t data;
    } tx_req_t;

    typedef struct packed {
        logic  ack;
        char_t data;
    } rx_rsp_t;

    typedef enum logic [$clog2(`DBG_NUM_FIELDS)-1:0] {
        F_NPC,
        F_PC,
        F_IR,
        F_CTL,
        F_A,
        F_B,
        F_IMM,
        F_Y,
        F_MDR
    } field_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DUMP,
        DONE
    } go_phase_e;

    typedef enum logic [1:0] {
        LABEL,
        VALUE,
        EOL
    } dump_state_e;

endpackage

`default_nettype wire

//--- src/dump_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbg_defines.svh"

module dump_sequencer
    import dbg_cpu_pkg::*, dbg_link_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       dump_start,
    input  wire logic       abort,
    input  wire cpu_state_t cpu,
    input  wire logic       tx_ack,
    output tx_req_t         tx,
    output logic            dump_done
);

    dump_state_e st;
    field_e      fld;
    logic [1:0]  idx;      // char position inside label or line end
    logic        busy;
    logic        req_q;

    word_t       lbl_word;
    logic [1:0]  lbl_last;
    char_t       lbl_char;
    word_t       fld_word;
    char_t       out_ch;
    logic        is_word;

    // labels right aligned, "=" always in the low byte
    always_comb begin
        case (fld)
            F_NPC:   lbl_word = 32'h4E50433D; // NPC=
            F_PC:    lbl_word = 32'h0050433D;
            F_IR:    lbl_word = 32'h0049523D;
            F_CTL:   lbl_word = 32'h43544C3D;
            F_A:     lbl_word = 32'h0000413D;
            F_B:     lbl_word = 32'h0000423D;
            F_IMM:   lbl_word = 32'h494D4D3D;
            F_Y:     lbl_word = 32'h0000593D;
            default: lbl_word = 32'h4D44523D; // MDR=
        endcase
    end

    // label length from the leading zero bytes
    assign lbl_last = (lbl_word[31:24] != '0) ? 2'd3 :
                      (lbl_word[23:16] != '0) ? 2'd2 :
                      (lbl_word[15:8]  != '0) ? 2'd1 : 2'd0;

    assign lbl_char = lbl_word[{lbl_last - idx, 3'b000} +: `DBG_CHAR_W];

    always_comb begin
        case (fld)
            F_NPC:   fld_word = cpu.npc;
            F_PC:    fld_word = cpu.pc;
            F_IR:    fld_word = cpu.ir;
            F_CTL:   fld_word = cpu.ctl;
            F_A:     fld_word = cpu.a;
            F_B:     fld_word = cpu.b;
            F_IMM:   fld_word = cpu.imm;
            F_Y:     fld_word = cpu.y;
            default: fld_word = cpu.mdr;
        endcase
    end

    always_comb begin
        is_word = 1'b0;
        out_ch  = lbl_char;
        case (st)
            VALUE:   is_word = 1'b1;
            EOL:     out_ch = (idx == 2'd0) ? `DBG_CR : `DBG_LF;
            default: ;
        endcase
    end

    assign tx = '{req: req_q, is_word: is_word,
                  data: is_word ? fld_word : word_t'(out_ch)};

    assign dump_done = busy && req_q && tx_ack && (st == EOL) && (idx == 2'd1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy  <= 1'b0;
            req_q <= 1'b0;
            st    <= LABEL;
            fld   <= F_NPC;
            idx   <= 2'd0;
        end else if (abort) begin
            busy  <= 1'b0;
            req_q <= 1'b0;
        end else if (dump_start) begin
            busy  <= 1'b1;
            req_q <= 1'b0;
            st    <= LABEL;
            fld   <= F_NPC;
            idx   <= 2'd0;
        end else if (busy) begin
            if (req_q && tx_ack) begin
                req_q <= 1'b0;
                case (st)
                    LABEL: begin
                        if (idx == lbl_last) begin
                            st  <= VALUE;
                            idx <= 2'd0;
                        end else begin
                            idx <= idx + 2'd1;
                        end
                    end
                    VALUE: begin
                        st  <= (fld == F_MDR) ? EOL : LABEL;
                        idx <= 2'd0;
                        if (fld != F_MDR)
                            fld <= field_e'(fld + 1'b1);
                    end
                    default: begin
                        if (idx == 2'd1)
                            busy <= 1'b0; // LF acked, dump over
                        else
                            idx <= 2'd1;
                    end
                endcase
            end else if (!req_q && !tx_ack) begin
                req_q <= 1'b1; // previous ack released
            end
        end
    end

    // payload held while the host stalls, cpu is frozen during the dump
    a_tx_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        tx.req && !tx_ack |=> $stable(tx.data) && $stable(tx.is_word)
    );

endmodule

`default_nettype wire

//--- src/go_phase_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbg_defines.svh"

module go_phase_ctrl
    import dbg_link_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire mode_t mode,
    input  wire logic  stop,
    input  wire logic  dump_done,
    output logic       run_en,
    output logic       dump_start,
    output logic       abort,
    output logic       finish
);

    go_phase_e phase;
    go_phase_e phase_nxt;
    logic      go_cmd;

    assign go_cmd = (mode == `DBG_GO_CMD);

    always_comb begin
        phase_nxt = phase;
        if (!go_cmd) begin
            phase_nxt = IDLE; // host left the command
        end else begin
            case (phase)
                IDLE:    phase_nxt = RUN;
                RUN:     if (stop) phase_nxt = DUMP;
                DUMP:    if (dump_done) phase_nxt = DONE;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase  <= IDLE;
            finish <= 1'b0;
        end else begin
            phase  <= phase_nxt;
            finish <= (phase_nxt == DONE);
        end
    end

    assign run_en     = (phase == RUN) && go_cmd;
    assign dump_start = (phase == RUN) && go_cmd && stop;
    assign abort      = (phase == DUMP) && !go_cmd;

    a_stop_in_run: assert property (
        @(posedge clk) disable iff (!rstn)
        stop |-> phase == RUN
    );

    a_done_in_dump: assert property (
        @(posedge clk) disable iff (!rstn)
        dump_done |-> phase == DUMP
    );

endmodule

`default_nettype wire

//--- src/run_control.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbg_defines.svh"

module run_control
    import dbg_cpu_pkg::*, dbg_link_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     run_en,
    input  wire word_t    pc_chk,
    input  wire bp_pair_t bps,
    input  wire rx_rsp_t  rx_rsp,
    output logic          rx_req,
    output logic          cpu_clk,
    output logic          stop
);

    logic bp_hit;
    logic halt_hit;

    assign bp_hit = (pc_chk == bps.bp1) || (pc_chk == bps.bp2);

    // only an acked "H" counts, anything else from the host is dropped
    assign halt_hit = rx_req && rx_rsp.ack && (rx_rsp.data == `DBG_HALT_CHAR);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cpu_clk <= 1'b0;
            rx_req  <= 1'b0;
            stop    <= 1'b0;
        end else if (run_en && !stop) begin
            cpu_clk <= ~cpu_clk;
            rx_req  <= !rx_rsp.ack; // one idle cycle after each ack
            stop    <= bp_hit || halt_hit;
        end else begin
            // stop cycle and everything after it park the cpu clock low
            cpu_clk <= 1'b0;
            rx_req  <= 1'b0;
            stop    <= 1'b0;
        end
    end

    // a stop ends the run, the cpu sees no further edge
    a_cpu_clk_parked: assert property (
        @(posedge clk) disable iff (!rstn)
        stop |=> !run_en && !cpu_clk
    );

endmodule

`default_nettype wire
